/* cache.f */
+incdir+common
common/cache_pkg.sv
logic/data_array.sv
logic/tag_array.sv
cache/plru.sv
cache/cache_ctrl.sv
cache/cache.sv
test/main_memory.sv
test/tb_cache.sv

/* cache/cache.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache (
    input  logic                    clk,
    input  logic                    rst_n,

    // cpu side, one word per request
    input  cache_pkg::addr_t        ufp_addr,
    input  cache_pkg::byte_mask_t   ufp_rmask,
    input  cache_pkg::byte_mask_t   ufp_wmask,
    input  cache_pkg::word_t        ufp_wdata,
    output cache_pkg::word_t        ufp_rdata,
    output logic                    ufp_resp,

    // memory side, whole lines
    output cache_pkg::addr_t        dfp_addr,
    output logic                    dfp_read,
    output logic                    dfp_write,
    output cache_pkg::line_t        dfp_wdata,
    input  cache_pkg::line_t        dfp_rdata,
    input  logic                    dfp_resp
);

    cache_pkg::set_idx_t            set_idx;
    cache_pkg::tag_t                req_tag;
    logic [`CACHE_OFFSET_BITS-3:0]  word_sel;
    logic                           req;

    cache_pkg::line_t               way_rdata [`CACHE_WAYS];
    cache_pkg::tag_entry_t          way_rentry [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]         hit_vec;
    logic [`CACHE_WAYS-1:0]         way_we;

    cache_pkg::lookup_t             lookup;
    cache_pkg::way_t                victim_way;
    cache_pkg::tag_entry_t          victim_entry;
    cache_pkg::array_op_e           array_op;

    cache_pkg::line_t               line_wdata;
    cache_pkg::line_mask_t          line_wmask;
    cache_pkg::tag_entry_t          wentry;

    assign set_idx  = ufp_addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    assign req_tag  = ufp_addr[`CACHE_OFFSET_BITS + `CACHE_INDEX_BITS +: `CACHE_TAG_BITS];
    assign word_sel = ufp_addr[`CACHE_OFFSET_BITS-1:2];
    assign req      = (ufp_rmask | ufp_wmask) != '0;

    assign victim_entry = way_rentry[victim_way];

    // tag compare across all ways
    always_comb begin
        lookup.hit_way = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            hit_vec[i] = way_rentry[i].valid && (way_rentry[i].tag == req_tag);
            if (hit_vec[i]) begin
                lookup.hit_way = cache_pkg::way_t'(i);
            end
        end
        lookup.hit          = |hit_vec;
        lookup.victim_dirty = victim_entry.valid && victim_entry.dirty;
    end

    assign ufp_rdata = way_rdata[lookup.hit_way][{word_sel, 5'b0} +: 32];

    // only the write enable differs per way
    always_comb begin
        way_we = '0;
        case (array_op)
            cache_pkg::ARRAY_HIT_WRITE:    way_we[lookup.hit_way] = 1'b1;
            cache_pkg::ARRAY_REFILL_WRITE: way_we[victim_way] = 1'b1;
            default:                       way_we = '0;
        endcase
    end

    always_comb begin
        wentry.valid = 1'b1;
        wentry.tag   = req_tag;
        if (array_op == cache_pkg::ARRAY_REFILL_WRITE) begin
            line_wdata   = dfp_rdata;
            line_wmask   = '1;
            wentry.dirty = 1'b0;
        end else begin
            // cpu word lands in every slot, the mask picks the bytes
            line_wdata   = {(`CACHE_LINE_BITS / 32){ufp_wdata}};
            line_wmask   = cache_pkg::line_mask_t'(ufp_wmask) << {word_sel, 2'b00};
            wentry.dirty = 1'b1;
        end
    end

    assign dfp_wdata = way_rdata[victim_way];

    always_comb begin
        dfp_addr = '0;
        if (dfp_write) begin
            dfp_addr = {victim_entry.tag, set_idx, {`CACHE_OFFSET_BITS{1'b0}}};
        end else if (dfp_read) begin
            dfp_addr = {req_tag, set_idx, {`CACHE_OFFSET_BITS{1'b0}}};
        end
    end

    cache_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .rmask      (ufp_rmask),
        .wmask      (ufp_wmask),
        .lookup     (lookup),
        .dfp_resp   (dfp_resp),
        .array_op   (array_op),
        .ufp_resp   (ufp_resp),
        .dfp_read   (dfp_read),
        .dfp_write  (dfp_write)
    );

    plru i_plru (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_idx    (set_idx),
        .ufp_resp   (ufp_resp),
        .visit_way  (lookup.hit_way),
        .victim_way (victim_way)
    );

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        data_array i_data (
            .clk     (clk),
            .en      (req),
            .we      (way_we[w]),
            .wmask   (line_wmask),
            .set_idx (set_idx),
            .wdata   (line_wdata),
            .rdata   (way_rdata[w])
        );

        tag_array i_tag (
            .clk     (clk),
            .rst_n   (rst_n),
            .en      (req),
            .we      (way_we[w]),
            .set_idx (set_idx),
            .wentry  (wentry),
            .rentry  (way_rentry[w])
        );
    end

    // a tag lives in at most one way of a set
    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> $onehot0(hit_vec))
        else $error("more than one way hits tag %h in set %0d", req_tag, set_idx);

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::byte_mask_t   rmask,
    input  cache_pkg::byte_mask_t   wmask,
    input  cache_pkg::lookup_t      lookup,
    input  logic                    dfp_resp,
    output cache_pkg::array_op_e    array_op,
    output logic                    ufp_resp,
    output logic                    dfp_read,
    output logic                    dfp_write
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e state_next;
    logic                   req;

    assign req = (rmask | wmask) != '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cache_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        array_op   = cache_pkg::ARRAY_NONE;
        ufp_resp   = 1'b0;
        case (state)
            cache_pkg::ST_IDLE: begin
                if (req) begin
                    state_next = cache_pkg::ST_COMPARE;
                end
            end
            cache_pkg::ST_COMPARE: begin
                if (lookup.hit) begin
                    ufp_resp   = 1'b1;
                    state_next = cache_pkg::ST_IDLE;
                    if (wmask != '0) begin
                        array_op = cache_pkg::ARRAY_HIT_WRITE;
                    end
                end else if (lookup.victim_dirty) begin
                    state_next = cache_pkg::ST_WRITEBACK;
                end else begin
                    state_next = cache_pkg::ST_ALLOCATE;
                end
            end
            cache_pkg::ST_WRITEBACK: begin
                if (dfp_resp) begin
                    state_next = cache_pkg::ST_ALLOCATE;
                end
            end
            cache_pkg::ST_ALLOCATE: begin
                if (dfp_resp) begin
                    array_op   = cache_pkg::ARRAY_REFILL_WRITE;
                    state_next = cache_pkg::ST_REFILL_READ;
                end
            end
            // one cycle for the refilled line to come out of the arrays
            cache_pkg::ST_REFILL_READ: state_next = cache_pkg::ST_COMPARE;
            default:                   state_next = cache_pkg::ST_IDLE;
        endcase
    end

    assign dfp_write = state == cache_pkg::ST_WRITEBACK;
    assign dfp_read  = state == cache_pkg::ST_ALLOCATE;

    // memory answers exactly one open request
    a_dfp_excl: assert property (@(posedge clk) disable iff (!rst_n)
        dfp_resp |-> dfp_read ^ dfp_write)
        else $error("dfp_resp without exactly one of dfp_read and dfp_write");

    // a refilled line hits on the next compare
    a_resp_in_compare: assert property (@(posedge clk) disable iff (!rst_n)
        state == cache_pkg::ST_REFILL_READ |=> lookup.hit)
        else $error("no hit in compare after a refill");

endmodule

/* cache/plru.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module plru (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::set_idx_t     set_idx,
    input  logic                    ufp_resp,
    input  cache_pkg::way_t         visit_way,
    output cache_pkg::way_t         victim_way
);

    cache_pkg::plru_tree_t trees [`CACHE_SETS];
    cache_pkg::plru_tree_t cur_tree;
    cache_pkg::plru_tree_t next_tree;

    assign cur_tree = trees[set_idx];

    // bit 0 picks the pair, bits 1 and 2 pick inside the left and right pair
    assign victim_way = cur_tree[0] ? {1'b1, cur_tree[2]} : {1'b0, cur_tree[1]};

    // point every node on the path away from the visited leaf
    always_comb begin
        next_tree    = cur_tree;
        next_tree[0] = ~visit_way[1];
        if (visit_way[1]) begin
            next_tree[2] = ~visit_way[0];
        end else begin
            next_tree[1] = ~visit_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                trees[i] <= '0;
            end
        end else if (ufp_resp) begin
            trees[set_idx] <= next_tree;
        end
    end

endmodule

/* common/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cache geometry
`define CACHE_WAYS          4
`define CACHE_SETS          16

// address split, offset then index then tag
`define CACHE_OFFSET_BITS   5
`define CACHE_INDEX_BITS    4
`define CACHE_TAG_BITS      23

// 32 bytes per line
`define CACHE_LINE_BITS     256

`endif

/* common/cache_pkg.sv */
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [31:0]                        addr_t;
    typedef logic [31:0]                        word_t;
    typedef logic [`CACHE_LINE_BITS-1:0]        line_t;
    typedef logic [3:0]                         byte_mask_t;
    typedef logic [`CACHE_LINE_BITS/8-1:0]      line_mask_t;
    typedef logic [`CACHE_TAG_BITS-1:0]         tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]       set_idx_t;
    typedef logic [1:0]                         way_t;

    // root, left pair, right pair
    typedef logic [2:0]                         plru_tree_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // what the controller needs from the compare
    typedef struct packed {
        logic hit;
        way_t hit_way;
        logic victim_dirty;
    } lookup_t;

    typedef enum logic [1:0] {
        ARRAY_NONE,
        ARRAY_HIT_WRITE,
        ARRAY_REFILL_WRITE
    } array_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_ALLOCATE,
        ST_REFILL_READ
    } ctrl_state_e;

endpackage

/* logic/data_array.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module data_array (
    input  logic                    clk,
    input  logic                    en,
    input  logic                    we,
    input  cache_pkg::line_mask_t   wmask,
    input  cache_pkg::set_idx_t     set_idx,
    input  cache_pkg::line_t        wdata,
    output cache_pkg::line_t        rdata
);

    cache_pkg::line_t lines [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < `CACHE_LINE_BITS / 8; i++) begin
                    if (wmask[i]) begin
                        lines[set_idx][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
            // read returns the old line on a same-cycle write
            rdata <= lines[set_idx];
        end
    end

endmodule

/* logic/tag_array.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module tag_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic                    we,
    input  cache_pkg::set_idx_t     set_idx,
    input  cache_pkg::tag_entry_t   wentry,
    output cache_pkg::tag_entry_t   rentry
);

    cache_pkg::tag_entry_t entries [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // invalidate every entry
            for (int i = 0; i < `CACHE_SETS; i++) begin
                entries[i].valid <= 1'b0;
            end
            rentry <= '0;
        end else if (en) begin
            if (we) begin
                entries[set_idx] <= wentry;
            end
            rentry <= entries[set_idx];
        end
    end

endmodule

/* test/main_memory.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

// line memory behind the dfp port, answers after a random wait
module main_memory #(
    parameter int LINES     = 4096,
    parameter int MAX_DELAY = 5,
    parameter int SEED      = 32'h7f1f
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::addr_t    addr,
    input  logic                read,
    input  logic                write,
    input  cache_pkg::line_t    wdata,
    output cache_pkg::line_t    rdata,
    output logic                resp
);

    cache_pkg::line_t           lines [LINES];
    logic [$clog2(LINES)-1:0]   idx;
    logic                       busy;
    int                         wait_left;
    integer                     seed;

    assign idx = addr[`CACHE_OFFSET_BITS +: $clog2(LINES)];

    // each word gets a value from its own word address
    initial begin
        seed = SEED;
        resp = 1'b0;
        busy = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            for (int w = 0; w < `CACHE_LINE_BITS / 32; w++) begin
                lines[i][32*w +: 32] = (i * (`CACHE_LINE_BITS / 32) + w) * 32'h9e3779b1 ^ SEED;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            resp <= 1'b0;
            busy <= 1'b0;
        end else if (resp) begin
            resp <= 1'b0;
        end else if (read || write) begin
            if (!busy) begin
                busy      <= 1'b1;
                wait_left <= $unsigned($random(seed)) % (MAX_DELAY + 1);
            end else if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                busy  <= 1'b0;
                resp  <= 1'b1;
                rdata <= lines[idx];
                if (write) begin
                    lines[idx] <= wdata;
                end
            end
        end
    end

endmodule

/* test/tb_cache.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module tb_cache;

    localparam int N_RANDOM     = 400;
    localparam int MAX_DELAY    = 5;
    localparam int MEM_LINES    = 4096;
    // writeback and refill both at the longest wait, plus the fsm overhead
    localparam int MISS_CYCLES  = 2 * (MAX_DELAY + 3) + 5;
    localparam int MAX_REQUESTS = 2 * N_RANDOM + 20;
    localparam int WATCHDOG_NS  = MAX_REQUESTS * MISS_CYCLES * 100 * 2;

    logic                   clk;
    logic                   rst_n;
    cache_pkg::addr_t       ufp_addr;
    cache_pkg::byte_mask_t  ufp_rmask;
    cache_pkg::byte_mask_t  ufp_wmask;
    cache_pkg::word_t       ufp_wdata;
    cache_pkg::word_t       ufp_rdata;
    logic                   ufp_resp;
    cache_pkg::addr_t       dfp_addr;
    logic                   dfp_read;
    logic                   dfp_write;
    cache_pkg::line_t       dfp_wdata;
    cache_pkg::line_t       dfp_rdata;
    logic                   dfp_resp;

    logic [7:0]             model_mem [MEM_LINES * 32];
    bit                     written_line [MEM_LINES];
    bit                     touched [MEM_LINES * 8];
    cache_pkg::addr_t       touched_q [$];
    cache_pkg::addr_t       req_addr;
    int                     tag_pool [6] = '{1, 2, 3, 7, 40, 200};
    int                     set_pool [2] = '{3, 12};
    integer                 seed;
    int                     check_count;
    int                     error_count;
    int                     wb_count;
    int                     test_count;
    int                     test_fails;

    cache i_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    main_memory #(.LINES(MEM_LINES), .MAX_DELAY(MAX_DELAY), .SEED(32'h7f1f)) i_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (dfp_addr),
        .read  (dfp_read),
        .write (dfp_write),
        .wdata (dfp_wdata),
        .rdata (dfp_rdata),
        .resp  (dfp_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a request never finished", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    task automatic check_word(input string name, input cache_pkg::word_t expected,
                              input cache_pkg::word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t expected,
                              input cache_pkg::addr_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    function automatic cache_pkg::word_t model_word(input cache_pkg::addr_t addr);
        return {model_mem[addr + 3], model_mem[addr + 2], model_mem[addr + 1], model_mem[addr]};
    endfunction

    function automatic cache_pkg::addr_t make_addr(input int tag, input int set, input int word);
        return (tag << (`CACHE_OFFSET_BITS + `CACHE_INDEX_BITS)) | (set << `CACHE_OFFSET_BITS)
               | (word << 2);
    endfunction

    function automatic int line_of(input cache_pkg::addr_t addr);
        return addr >> `CACHE_OFFSET_BITS;
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count != errs_before) begin
            test_fails++;
        end
        $display("test %s: %s", name, (error_count == errs_before) ? "passed" : "failed");
    endtask

    // one cpu request, held until ufp_resp, then the model takes the write
    task automatic run_request(input cache_pkg::addr_t addr, input cache_pkg::byte_mask_t rmask,
                               input cache_pkg::byte_mask_t wmask, input cache_pkg::word_t wdata,
                               output int cycles, output logic dfp_seen);
        cache_pkg::word_t expected;
        cycles   = 0;
        dfp_seen = 1'b0;
        req_addr = addr;
        expected = model_word(addr);
        @(posedge clk);
        ufp_addr  <= addr;
        ufp_rmask <= rmask;
        ufp_wmask <= wmask;
        ufp_wdata <= wdata;
        do begin
            @(posedge clk);
            cycles++;
            dfp_seen = dfp_seen | dfp_read | dfp_write;
        end while (ufp_resp !== 1'b1);
        if (rmask != '0) begin
            check_word("ufp_rdata", expected, ufp_rdata);
        end
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) begin
                model_mem[addr + b] = wdata[8*b +: 8];
            end
        end
        if (wmask != '0) begin
            written_line[line_of(addr)] = 1'b1;
        end
        if (!touched[addr >> 2]) begin
            touched[addr >> 2] = 1'b1;
            touched_q.push_back(addr);
        end
        ufp_rmask <= '0;
        ufp_wmask <= '0;
    endtask

    // dfp side, checked on the response cycle
    always @(posedge clk) begin
        if (rst_n && dfp_resp && dfp_write) begin
            wb_count++;
            if (!written_line[line_of(dfp_addr)]) begin
                error_count++;
                $display("unexpected writeback at %0t ns of clean line %h", $time, dfp_addr);
            end
            for (int w = 0; w < `CACHE_LINE_BITS / 32; w++) begin
                check_word("dfp_wdata", model_word(dfp_addr + 4 * w), dfp_wdata[32*w +: 32]);
            end
            written_line[line_of(dfp_addr)] = 1'b0;
        end
        if (rst_n && dfp_resp && dfp_read) begin
            check_addr("dfp_addr", {req_addr[31:`CACHE_OFFSET_BITS], {`CACHE_OFFSET_BITS{1'b0}}},
                       dfp_addr);
            written_line[line_of(dfp_addr)] = 1'b0;
        end
    end

    initial begin
        int                     cycles;
        logic                   dfp_seen;
        int                     errs;
        int                     wb_before;
        cache_pkg::addr_t       addr;
        cache_pkg::byte_mask_t  mask;
        seed        = 32'h7f1f;
        rst_n       = 1'b0;
        ufp_addr    = '0;
        ufp_rmask   = '0;
        ufp_wmask   = '0;
        ufp_wdata   = '0;
        check_count = 0;
        error_count = 0;
        wb_count    = 0;
        test_count  = 0;
        test_fails  = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < MEM_LINES * 32; i++) begin
            model_mem[i] = i_mem.lines[i / 32][8 * (i % 32) +: 8];
        end

        errs = error_count;
        @(posedge clk);
        check_bit("ufp_resp", 1'b0, ufp_resp);
        check_bit("dfp_read", 1'b0, dfp_read);
        check_bit("dfp_write", 1'b0, dfp_write);
        finish_test("reset_state", errs);

        // first access misses, the next two must hit
        errs = error_count;
        run_request(make_addr(50, 6, 3), 4'hf, '0, '0, cycles, dfp_seen);
        run_request(make_addr(50, 6, 3), '0, 4'h6, 32'hcafe_f00d, cycles, dfp_seen);
        check_bit("ufp_resp in cycle 2", 1'b1, cycles == 2);
        check_bit("dfp_read or dfp_write", 1'b0, dfp_seen);
        run_request(make_addr(50, 6, 3), 4'hf, '0, '0, cycles, dfp_seen);
        check_bit("ufp_resp in cycle 2", 1'b1, cycles == 2);
        check_bit("dfp_read or dfp_write", 1'b0, dfp_seen);
        finish_test("hit_timing", errs);

        errs      = error_count;
        wb_before = wb_count;
        for (int t = 0; t < 5; t++) begin
            run_request(make_addr(100 + t, 9, t), '0, 4'hf, $random(seed), cycles, dfp_seen);
        end
        check_bit("dfp_write after five tags", 1'b1, wb_count > wb_before);
        finish_test("dirty_eviction", errs);

        errs = error_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            addr = make_addr(tag_pool[$unsigned($random(seed)) % 6],
                             set_pool[$unsigned($random(seed)) % 2], $unsigned($random(seed)) % 8);
            mask = $random(seed);
            if (mask == '0) begin
                mask = 4'hf;
            end
            if ($random(seed) & 1) begin
                run_request(addr, '0, mask, $random(seed), cycles, dfp_seen);
            end else begin
                run_request(addr, mask, '0, '0, cycles, dfp_seen);
            end
        end
        finish_test("random_traffic", errs);

        errs = error_count;
        foreach (touched_q[i]) begin
            run_request(touched_q[i], 4'hf, '0, '0, cycles, dfp_seen);
        end
        finish_test("readback_sweep", errs);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, test_fails, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
